//--- logic/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Keyboard codes
`define KEY_START       8'd40
`define KEY_CONTINUE    8'd44

// Sprite sizes in pixels
`define BALL_BIG        20
`define BALL_SMALL      10
`define SIZE_W          10

// Player lives
`define LIVES_INIT      3
`define LIVES_W         3

// Round counter from the score logic
`define ROUND_W         10
`define FINAL_ROUND     9

`define NUM_KEYS        4
`define NUM_SLOTS       4

`endif

//--- logic/game_pkg.sv
`default_nettype none

`include "game_defs.svh"

package game_pkg;

    // One code per keyboard slot, slot 0 in the low byte
    typedef struct packed {
        logic [`NUM_KEYS-1:0][7:0] code;
    } key_set_t;

    typedef struct packed {
        logic              in_play;
        logic [`SIZE_W-1:0] size;
    } ball_t;

    typedef struct packed {
        ball_t parent;
        ball_t child;
    } pair_view_t;

    typedef struct packed {
        ball_t slot_1;
        ball_t slot_2;
        ball_t slot_3;
        ball_t slot_4;
    } arena_view_t;

    // Bullet hit per ball slot, indexed from 1
    typedef struct packed {
        logic [`NUM_SLOTS:1] slot;
    } hit_set_t;

    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_PLAY = 2'd1,
        MODE_OVER = 2'd2
    } game_mode_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PLAY,
        PH_LIFE_LOST,
        PH_LEVEL_CLEAR,
        PH_OVER
    } phase_t;

    typedef enum logic {
        LEVEL_1,
        LEVEL_2
    } level_t;

endpackage

`default_nettype wire

//--- logic/ball_pair.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module ball_pair
(
    input  logic                 Clk,
    input  logic                 rst,
    input  logic                 active,
    input  logic [1:0]           hits,
    output game_pkg::pair_view_t view,
    output logic                 split,
    output logic                 cleared
);

    typedef enum logic [1:0] {
        PAIR_WHOLE,
        PAIR_SPLIT,
        PAIR_ONE,
        PAIR_CLEAR
    } pair_state_t;

    pair_state_t state;
    pair_state_t state_next;
    logic        parent_on;
    logic        child_on;

    always_ff @(posedge Clk)
    begin
        if (rst)
            state <= PAIR_WHOLE;
        else
            state <= state_next;
    end

    // hits[1] is the parent slot, hits[0] the child slot
    always_comb
    begin
        state_next = state;
        if (!active)
        begin
            state_next = PAIR_WHOLE;
        end
        else
        begin
            case (state)
                PAIR_WHOLE:
                    if (hits[1])
                        state_next = PAIR_SPLIT;
                PAIR_SPLIT:
                    if (hits == 2'b11)
                        state_next = PAIR_CLEAR;
                    else if (hits != 2'b00)
                        state_next = PAIR_ONE;
                PAIR_ONE:
                    if (hits != 2'b00)
                        state_next = PAIR_CLEAR;
                default:
                    state_next = PAIR_CLEAR;
            endcase
        end
    end

    assign parent_on = active && (state != PAIR_CLEAR);
    assign child_on  = active && (state == PAIR_SPLIT || state == PAIR_ONE);

    always_comb
    begin
        view.parent.in_play = parent_on;
        view.child.in_play  = child_on;
        view.parent.size    = '0;
        view.child.size     = '0;
        if (parent_on)
        begin
            if (state == PAIR_WHOLE)
                view.parent.size = `SIZE_W'(`BALL_BIG);
            else
                view.parent.size = `SIZE_W'(`BALL_SMALL);
        end
        if (child_on)
            view.child.size = `SIZE_W'(`BALL_SMALL);
    end

    assign split   = (state != PAIR_WHOLE);
    assign cleared = (state == PAIR_CLEAR);

endmodule

`default_nettype wire

//--- logic/game_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module game_sequencer
(
    input  logic                 Clk,
    input  logic                 rst,
    input  game_pkg::key_set_t   keys,
    input  logic                 collide,
    input  logic [`ROUND_W-1:0]  round,
    input  logic                 split_a,
    input  logic                 split_b,
    input  logic                 cleared_a,
    input  logic                 cleared_b,
    output logic                 active_a,
    output logic                 active_b,
    output game_pkg::game_mode_t mode,
    output logic [`LIVES_W-1:0]  lives,
    output logic                 level_up,
    output logic                 cont,
    output logic                 power_possible
);

    import game_pkg::*;

    phase_t phase;
    phase_t phase_next;
    level_t level;
    level_t level_next;
    logic   start_key;
    logic   cont_key;
    logic   all_clear;

    // Any of the keyboard slots may carry the key
    always_comb
    begin
        start_key = 1'b0;
        cont_key  = 1'b0;
        for (int i = 0; i < `NUM_KEYS; i++)
        begin
            if (keys.code[i] == `KEY_START)
                start_key = 1'b1;
            if (keys.code[i] == `KEY_CONTINUE)
                cont_key = 1'b1;
        end
    end

    // Pair B only counts on level 2
    assign all_clear = cleared_a && (level == LEVEL_1 || cleared_b);

    always_comb
    begin
        phase_next = phase;
        level_next = level;
        case (phase)
            PH_IDLE:
                if (start_key)
                begin
                    phase_next = PH_PLAY;
                    level_next = LEVEL_1;
                end
            PH_PLAY:
                if (collide)
                begin
                    if (lives == '0)
                        phase_next = PH_OVER;
                    else
                        phase_next = PH_LIFE_LOST;
                end
                else if (all_clear)
                begin
                    phase_next = PH_LEVEL_CLEAR;
                end
            PH_LIFE_LOST:
                phase_next = PH_PLAY;
            PH_LEVEL_CLEAR:
                if (round == `ROUND_W'(`FINAL_ROUND))
                begin
                    phase_next = PH_IDLE;
                    level_next = LEVEL_1;
                end
                else
                begin
                    phase_next = PH_PLAY;
                    level_next = (level == LEVEL_1) ? LEVEL_2 : LEVEL_1;
                end
            PH_OVER:
                if (cont_key)
                    phase_next = PH_IDLE;
            default:
                phase_next = PH_IDLE;
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            phase <= PH_IDLE;
            level <= LEVEL_1;
        end
        else
        begin
            phase <= phase_next;
            level <= level_next;
        end
    end

    // Reload on the way into idle so lives are full as soon as idle shows
    always_ff @(posedge Clk)
    begin
        if (rst || phase == PH_IDLE || phase_next == PH_IDLE)
            lives <= `LIVES_W'(`LIVES_INIT);
        else if (phase == PH_PLAY && collide && lives != '0)
            lives <= lives - 1'b1;
    end

    always_comb
    begin
        case (phase)
            PH_IDLE:
                mode = MODE_IDLE;
            PH_OVER:
                mode = MODE_OVER;
            default:
                mode = MODE_PLAY;
        endcase
    end

    assign active_a       = (phase == PH_PLAY);
    assign active_b       = (phase == PH_PLAY) && (level == LEVEL_2);
    assign level_up       = (phase == PH_LEVEL_CLEAR);
    assign cont           = (phase == PH_LIFE_LOST);
    assign power_possible = (level == LEVEL_2) && split_a && split_b;

endmodule

`default_nettype wire

//--- logic/arena_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module arena_control
(
    input  logic                  Clk,
    input  logic                  rst,
    input  game_pkg::key_set_t    keys,
    input  game_pkg::hit_set_t    hits,
    input  logic                  collide,
    input  logic [`ROUND_W-1:0]   round,
    output game_pkg::game_mode_t  mode,
    output game_pkg::arena_view_t balls,
    output logic [`LIVES_W-1:0]   lives,
    output logic                  level_up,
    output logic                  cont,
    output logic                  power_possible
);

    import game_pkg::*;

    pair_view_t view_a;
    pair_view_t view_b;
    logic       active_a;
    logic       active_b;
    logic       split_a;
    logic       split_b;
    logic       cleared_a;
    logic       cleared_b;

    game_sequencer u_seq
    (
        .Clk            (Clk),
        .rst            (rst),
        .keys           (keys),
        .collide        (collide),
        .round          (round),
        .split_a        (split_a),
        .split_b        (split_b),
        .cleared_a      (cleared_a),
        .cleared_b      (cleared_b),
        .active_a       (active_a),
        .active_b       (active_b),
        .mode           (mode),
        .lives          (lives),
        .level_up       (level_up),
        .cont           (cont),
        .power_possible (power_possible)
    );

    // Pair A owns slots 1 and 2
    ball_pair u_pair_a
    (
        .Clk     (Clk),
        .rst     (rst),
        .active  (active_a),
        .hits    ({hits.slot[1], hits.slot[2]}),
        .view    (view_a),
        .split   (split_a),
        .cleared (cleared_a)
    );

    // Pair B owns slots 3 and 4
    ball_pair u_pair_b
    (
        .Clk     (Clk),
        .rst     (rst),
        .active  (active_b),
        .hits    ({hits.slot[3], hits.slot[4]}),
        .view    (view_b),
        .split   (split_b),
        .cleared (cleared_b)
    );

    assign balls.slot_1 = view_a.parent;
    assign balls.slot_2 = view_a.child;
    assign balls.slot_3 = view_b.parent;
    assign balls.slot_4 = view_b.child;

endmodule

`default_nettype wire

//--- sim/arena_control_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module arena_control_sva
(
    input logic                  Clk,
    input logic                  rst,
    input game_pkg::key_set_t    keys,
    input game_pkg::hit_set_t    hits,
    input logic                  collide,
    input logic [`ROUND_W-1:0]   round,
    input game_pkg::game_mode_t  mode,
    input game_pkg::arena_view_t balls,
    input logic [`LIVES_W-1:0]   lives,
    input logic                  level_up,
    input logic                  cont,
    input logic                  power_possible
);

    import game_pkg::*;

    localparam logic [`SIZE_W-1:0]  BIG        = `SIZE_W'(`BALL_BIG);
    localparam logic [`SIZE_W-1:0]  SMALL      = `SIZE_W'(`BALL_SMALL);
    localparam logic [`LIVES_W-1:0] LIVES_FULL = `LIVES_W'(`LIVES_INIT);

    int                  fail_count = 0;
    logic                in_play;
    logic                start_key;
    logic                cont_key;
    logic                on_level_2;
    logic [`LIVES_W-1:0] lives_exp;
    int                  pops_a;
    int                  pops_b;
    int                  hits_a;
    int                  hits_b;

    task automatic report_failure(input string msg);
        fail_count++;
        $error("%s", msg);
    endtask

    function automatic logic is_ball(input ball_t b, input logic [`SIZE_W-1:0] size);
        return b.in_play && b.size == size;
    endfunction

    // Play phase proper, without the pulse cycles
    assign in_play = mode == MODE_PLAY && !cont && !level_up;

    assign start_key = keys.code[0] == `KEY_START || keys.code[1] == `KEY_START
                    || keys.code[2] == `KEY_START || keys.code[3] == `KEY_START;
    assign cont_key  = keys.code[0] == `KEY_CONTINUE || keys.code[1] == `KEY_CONTINUE
                    || keys.code[2] == `KEY_CONTINUE || keys.code[3] == `KEY_CONTINUE;

    assign hits_a = int'(hits.slot[1]) + int'(hits.slot[2]);
    assign hits_b = int'(hits.slot[3]) + int'(hits.slot[4]);

    // Expected level, pops seen on each split pair, expected lives
    always_ff @(posedge Clk)
    begin
        if (rst || mode == MODE_IDLE)
            on_level_2 <= 1'b0;
        else if (level_up && round != `FINAL_ROUND)
            on_level_2 <= !on_level_2;
        if (rst || !in_play || collide || balls.slot_1.size != SMALL)
            pops_a <= 0;
        else
            pops_a <= pops_a + hits_a;
        if (rst || !in_play || collide || balls.slot_3.size != SMALL)
            pops_b <= 0;
        else
            pops_b <= pops_b + hits_b;
        if (rst || mode == MODE_IDLE)
            lives_exp <= LIVES_FULL;
        else if (in_play && collide && lives_exp != '0)
            lives_exp <= lives_exp - 1'b1;
    end

    assert property (@(posedge Clk)
        rst |=> mode == MODE_IDLE && balls == '0 && !level_up && !cont && !power_possible
            && lives == LIVES_FULL)
        else report_failure($sformatf("** Error %0t: after reset lives got %0d expected %0d",
            $time, $sampled(lives), LIVES_FULL));

    assert property (@(posedge Clk) disable iff (rst)
        !in_play |-> balls == '0)
        else report_failure($sformatf("** Error %0t: balls got %h expected 0",
            $time, $sampled(balls)));

    assert property (@(posedge Clk) disable iff (rst)
        mode == MODE_IDLE && start_key |=> mode == MODE_PLAY && is_ball(balls.slot_1, BIG))
        else report_failure($sformatf("** Error %0t: mode got %0d expected %0d",
            $time, $sampled(mode), MODE_PLAY));

    assert property (@(posedge Clk) disable iff (rst)
        in_play && !collide && is_ball(balls.slot_1, BIG) && hits.slot[1]
        |=> is_ball(balls.slot_1, SMALL) && is_ball(balls.slot_2, SMALL))
        else report_failure($sformatf("** Error %0t: slot_1 size got %0d expected %0d",
            $time, $sampled(balls.slot_1.size), SMALL));

    assert property (@(posedge Clk) disable iff (rst)
        in_play && !collide && is_ball(balls.slot_3, BIG) && hits.slot[3]
        |=> is_ball(balls.slot_3, SMALL) && is_ball(balls.slot_4, SMALL))
        else report_failure($sformatf("** Error %0t: slot_3 size got %0d expected %0d",
            $time, $sampled(balls.slot_3.size), SMALL));

    assert property (@(posedge Clk) disable iff (rst)
        in_play && !collide && is_ball(balls.slot_1, SMALL) && pops_a + hits_a < 2
        |=> is_ball(balls.slot_1, SMALL) && is_ball(balls.slot_2, SMALL))
        else report_failure("Pair A left play before its second pop");

    assert property (@(posedge Clk) disable iff (rst)
        in_play && !collide && is_ball(balls.slot_1, SMALL) && pops_a + hits_a >= 2
        |=> !balls.slot_1.in_play && !balls.slot_2.in_play)
        else report_failure($sformatf("** Error %0t: slot_1 in_play got %0d expected 0",
            $time, $sampled(balls.slot_1.in_play)));

    assert property (@(posedge Clk) disable iff (rst)
        in_play && !collide && is_ball(balls.slot_3, SMALL) && pops_b + hits_b >= 2
        |=> !balls.slot_3.in_play && !balls.slot_4.in_play)
        else report_failure($sformatf("** Error %0t: slot_3 in_play got %0d expected 0",
            $time, $sampled(balls.slot_3.in_play)));

    assert property (@(posedge Clk) disable iff (rst)
        in_play && !collide && !balls.slot_1.in_play && (!on_level_2 || !balls.slot_3.in_play)
        |=> level_up)
        else report_failure($sformatf("** Error %0t: level_up got %0d expected 1",
            $time, $sampled(level_up)));

    assert property (@(posedge Clk) disable iff (rst)
        level_up && round != `FINAL_ROUND && !on_level_2
        |=> !level_up && is_ball(balls.slot_1, BIG) && is_ball(balls.slot_3, BIG))
        else report_failure("Level 2 did not start with slots 1 and 3 whole");

    assert property (@(posedge Clk) disable iff (rst)
        level_up && round != `FINAL_ROUND && on_level_2
        |=> !level_up && is_ball(balls.slot_1, BIG) && !balls.slot_3.in_play)
        else report_failure("Level 1 did not start with only slot 1 whole");

    assert property (@(posedge Clk) disable iff (rst)
        level_up && round == `FINAL_ROUND |=> mode == MODE_IDLE)
        else report_failure($sformatf("** Error %0t: mode got %0d expected %0d",
            $time, $sampled(mode), MODE_IDLE));

    assert property (@(posedge Clk) disable iff (rst)
        in_play && collide && lives_exp != '0 |=> cont && lives == lives_exp)
        else report_failure($sformatf("** Error %0t: lives got %0d expected %0d",
            $time, $sampled(lives), $sampled(lives_exp)));

    assert property (@(posedge Clk) disable iff (rst)
        in_play && collide && lives_exp != '0 |=> ##1 !cont && is_ball(balls.slot_1, BIG))
        else report_failure("Parent ball not restored whole one cycle after the lost life");

    assert property (@(posedge Clk) disable iff (rst)
        in_play && collide && lives_exp == '0 |=> mode == MODE_OVER && balls == '0)
        else report_failure($sformatf("** Error %0t: mode got %0d expected %0d",
            $time, $sampled(mode), MODE_OVER));

    assert property (@(posedge Clk) disable iff (rst)
        mode == MODE_OVER && cont_key |=> mode == MODE_IDLE && lives == LIVES_FULL)
        else report_failure($sformatf("** Error %0t: lives got %0d expected %0d",
            $time, $sampled(lives), LIVES_FULL));

    assert property (@(posedge Clk) disable iff (rst)
        in_play && on_level_2 && balls.slot_1.size == SMALL && balls.slot_3.size == SMALL
        |-> power_possible)
        else report_failure($sformatf("** Error %0t: power_possible got %0d expected 1",
            $time, $sampled(power_possible)));

endmodule

`default_nettype wire

//--- sim/arena_control_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module arena_control_tb;

    import game_pkg::*;

    // Rough cycle counts of the six tests
    localparam int TEST_CYCLES = 4 + 8 + 30 + 12 + 24 + 20;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;
    localparam int WAIT_LIMIT  = 20;

    localparam int GOAL_PLAY  = 0;
    localparam int GOAL_IDLE  = 1;
    localparam int GOAL_OVER  = 2;
    localparam int GOAL_LEVEL = 3;

    logic                Clk;
    logic                rst;
    key_set_t            keys;
    hit_set_t            hits;
    logic                collide;
    logic [`ROUND_W-1:0] round;
    game_mode_t          mode;
    arena_view_t         balls;
    logic [`LIVES_W-1:0] lives;
    logic                level_up;
    logic                cont;
    logic                power_possible;

    logic [15:0] lfsr_state  = 16'd40393;
    int          cycle_count = 0;
    int          wait_errors = 0;
    int          tests_done  = 0;

    arena_control uut
    (
        .Clk            (Clk),
        .rst            (rst),
        .keys           (keys),
        .hits           (hits),
        .collide        (collide),
        .round          (round),
        .mode           (mode),
        .balls          (balls),
        .lives          (lives),
        .level_up       (level_up),
        .cont           (cont),
        .power_possible (power_possible)
    );

    bind arena_control arena_control_sva u_sva
    (
        .Clk            (Clk),
        .rst            (rst),
        .keys           (keys),
        .hits           (hits),
        .collide        (collide),
        .round          (round),
        .mode           (mode),
        .balls          (balls),
        .lives          (lives),
        .level_up       (level_up),
        .cont           (cont),
        .power_possible (power_possible)
    );

    initial
    begin
        Clk = 1'b0;
        forever
            #2 Clk = ~Clk;
    end

    always @(posedge Clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic int rand_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            value = (value << 1) | lfsr_state[0];
        end
        return value;
    endfunction

    function automatic logic [`NUM_SLOTS:1] slot_bit(input int n);
        logic [`NUM_SLOTS:1] mask;
        mask    = '0;
        mask[n] = 1'b1;
        return mask;
    endfunction

    function automatic logic reached(input int goal);
        case (goal)
            GOAL_PLAY: return mode == MODE_PLAY && !cont && !level_up;
            GOAL_IDLE: return mode == MODE_IDLE;
            GOAL_OVER: return mode == MODE_OVER;
            default:   return level_up;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge Clk);
        #1;
    endtask

    task automatic wait_for(input int goal);
        int n;
        n = 0;
        while (!reached(goal) && n < WAIT_LIMIT)
        begin
            next_cycle();
            n++;
        end
        if (!reached(goal))
        begin
            wait_errors++;
            $display("At %0t goal %0d was not reached within %0d cycles",
                     $time, goal, WAIT_LIMIT);
        end
    endtask

    task automatic press_key(input logic [7:0] code);
        int slot;
        slot           = rand_bits(2);
        keys.code[slot] = code;
        next_cycle();
        keys = '0;
    endtask

    task automatic fire_hits(input logic [`NUM_SLOTS:1] mask);
        hits.slot = mask;
        next_cycle();
        hits = '0;
    endtask

    // Two single pops, order taken from the LFSR
    task automatic pop_pair(input int parent);
        logic [`NUM_SLOTS:1] first;
        logic [`NUM_SLOTS:1] second;
        first  = slot_bit(parent);
        second = slot_bit(parent + 1);
        if (rand_bits(1) == 1)
        begin
            first  = slot_bit(parent + 1);
            second = slot_bit(parent);
        end
        fire_hits(first);
        fire_hits(second);
    endtask

    task automatic raise_collide();
        collide = 1'b1;
        next_cycle();
        collide = 1'b0;
    endtask

    task automatic report_test(input string name);
        tests_done++;
        $display("Test %0d %s finished, failures so far %0d", tests_done, name,
                 wait_errors + uut.u_sva.fail_count);
    endtask

    initial
    begin
        rst     = 1'b1;
        keys    = '0;
        hits    = '0;
        collide = 1'b0;
        round   = '0;
        repeat (2) @(posedge Clk);
        #1;
        rst = 1'b0;
        next_cycle();
        report_test("reset_state");

        press_key(`KEY_START);
        wait_for(GOAL_PLAY);
        fire_hits(slot_bit(1));
        next_cycle();
        report_test("start_and_split");

        pop_pair(1);
        wait_for(GOAL_LEVEL);
        wait_for(GOAL_PLAY);
        // Both parents at once on level 2
        fire_hits(slot_bit(1) | slot_bit(3));
        next_cycle();
        fire_hits(slot_bit(1) | slot_bit(2));
        pop_pair(3);
        wait_for(GOAL_LEVEL);
        wait_for(GOAL_PLAY);
        report_test("level_clear_and_power");

        fire_hits(slot_bit(1));
        raise_collide();
        wait_for(GOAL_PLAY);
        report_test("life_lost");

        raise_collide();
        wait_for(GOAL_PLAY);
        raise_collide();
        wait_for(GOAL_PLAY);
        raise_collide();
        wait_for(GOAL_OVER);
        press_key(`KEY_CONTINUE);
        wait_for(GOAL_IDLE);
        report_test("game_over_and_continue");

        round = `ROUND_W'(`FINAL_ROUND);
        press_key(`KEY_START);
        wait_for(GOAL_PLAY);
        fire_hits(slot_bit(1));
        pop_pair(1);
        wait_for(GOAL_LEVEL);
        wait_for(GOAL_IDLE);
        round = '0;
        next_cycle();
        report_test("final_round");

        if (wait_errors + uut.u_sva.fail_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $display("Tests run %0d, assertion failures %0d, wait failures %0d",
                 tests_done, uut.u_sva.fail_count, wait_errors);
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/game_pkg.sv
logic/ball_pair.sv
logic/game_sequencer.sv
logic/arena_control.sv
sim/arena_control_sva.sv
sim/arena_control_tb.sv
